// File: build.f
source/raycast_pkg.sv
source/block_bus_if.sv
source/apb_block_port.sv
source/block_table_arbiter.sv
source/pixel_ray_gen.sv
source/get_intersecting_block.sv
source/ray_caster_top.sv
verif/ray_caster_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the ray caster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module ray_caster_tb -o sim_ray_caster

./obj_dir/sim_ray_caster | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

// File: source/apb_block_port.sv
`timescale 1ns/1ps

module apb_block_port import raycast_pkg::*; #(
    parameter int NUM_BLOCKS = 12
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [BLK_IDX_W-1:0] paddr,
    input  logic [WORD_W-1:0]    pwdata,
    output logic [WORD_W-1:0]    prdata,
    output logic                 pready,
    output logic                 pslverr,
    block_bus_if.requester       bus
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQ     = 2'd1;
    localparam logic [1:0] ST_RD_WAIT = 2'd2;

    logic [1:0] state;
    logic       access;
    logic       bad_addr;

    assign access   = psel && penable;
    assign bad_addr = paddr >= BLK_IDX_W'(NUM_BLOCKS);

    // out of range addresses never reach the table
    assign bus.req   = (state == ST_REQ) && access && !bad_addr;
    assign bus.we    = pwrite;
    assign bus.addr  = paddr;
    assign bus.wdata.raw = pwdata;

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        case (state)
            ST_REQ: begin
                if (access && bad_addr) begin
                    pready  = 1'b1;
                    pslverr = 1'b1;
                end else if (access && bus.gnt && pwrite) begin
                    pready = 1'b1;
                end
            end
            ST_RD_WAIT: pready = 1'b1;
            default: pready = 1'b0;
        endcase
        prdata = (state == ST_RD_WAIT) ? bus.rdata.raw : '0;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (psel) state <= ST_REQ;
                ST_REQ: begin
                    if (access && (bad_addr || (bus.gnt && pwrite))) begin
                        state <= ST_IDLE;
                    end else if (access && bus.gnt) begin
                        state <= ST_RD_WAIT;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // completion only inside an access phase
    a_pready_in_access: assert property (@(posedge clk_in) disable iff (rst_in)
        pready |-> psel && penable);

endmodule

// File: source/block_bus_if.sv
`timescale 1ns/1ps

interface block_bus_if import raycast_pkg::*; ();

    logic                 req;
    logic                 we;
    logic [BLK_IDX_W-1:0] addr;
    block_word_u          wdata;
    logic                 gnt;
    // valid the cycle after gnt
    block_word_u          rdata;

    // request side holds req, we, addr, wdata until gnt
    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// File: source/block_table_arbiter.sv
`timescale 1ns/1ps

module block_table_arbiter import raycast_pkg::*; #(
    parameter int NUM_BLOCKS = 12
) (
    input  logic         clk_in,
    input  logic         rst_in,
    block_bus_if.arbiter apb_bus,
    block_bus_if.arbiter scan_bus
);

    block_word_u table_q [NUM_BLOCKS];
    block_word_u rdata_q;

    logic                 any_gnt;
    logic                 sel_we;
    logic [BLK_IDX_W-1:0] sel_addr;
    block_word_u          sel_wdata;
    logic                 in_range;

    ////////////////////////////////////////
    // fixed priority, apb first
    ////////////////////////////////////////

    always_comb begin
        apb_bus.gnt  = apb_bus.req;
        scan_bus.gnt = scan_bus.req && !apb_bus.req;
        any_gnt      = apb_bus.gnt || scan_bus.gnt;
    end

    // steer the granted side onto the table port
    always_comb begin
        if (apb_bus.gnt) begin
            sel_we    = apb_bus.we;
            sel_addr  = apb_bus.addr;
            sel_wdata = apb_bus.wdata;
        end else begin
            sel_we    = scan_bus.we;
            sel_addr  = scan_bus.addr;
            sel_wdata = scan_bus.wdata;
        end
        in_range = sel_addr < BLK_IDX_W'(NUM_BLOCKS);
    end

    ////////////////////////////////////////
    // table storage
    ////////////////////////////////////////

    // cleared to zero so every block starts invisible
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < NUM_BLOCKS; i++) begin
                table_q[i] <= '0;
            end
        end else if (any_gnt && sel_we && in_range) begin
            table_q[sel_addr] <= sel_wdata;
        end
    end

    always_ff @(posedge clk_in) begin
        if (any_gnt && !sel_we && in_range) begin
            rdata_q <= table_q[sel_addr];
        end
    end

    // one read register, only the side granted last cycle samples it
    assign apb_bus.rdata  = rdata_q;
    assign scan_bus.rdata = rdata_q;

    // requesters keep every granted access inside the table
    a_gnt_in_range: assert property (@(posedge clk_in) disable iff (rst_in)
        any_gnt |-> in_range);

endmodule

// File: source/get_intersecting_block.sv
`timescale 1ns/1ps

module get_intersecting_block import raycast_pkg::*; #(
    parameter int NUM_BLOCKS  = 12,
    parameter int FOCAL_SHIFT = 8,
    parameter int BLOCK_SIZE  = 64
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  ray_dir_t             ray,
    input  logic                 ray_valid,
    output logic                 ray_ready,
    block_bus_if.requester       bus,
    output logic [PIX_X_W-1:0]   hit_x,
    output logic [PIX_Y_W-1:0]   hit_y,
    output logic [BLK_IDX_W-1:0] hit_block,
    output logic [DEPTH_W-1:0]   hit_depth,
    output logic                 hit_valid,
    input  logic                 hit_ready
);

    // wide enough for dir * z and the shifted bounds
    localparam int CMP_W = 32;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    localparam logic [BLK_IDX_W-1:0] LAST_IDX = BLK_IDX_W'(NUM_BLOCKS - 1);

    logic [1:0]           state;
    ray_dir_t             ray_q;
    logic [BLK_IDX_W-1:0] idx;
    logic [BLK_IDX_W-1:0] rd_idx;
    logic                 rd_pending;
    block_entry_t         entry;

    logic signed [CMP_W-1:0] dir_x_ext;
    logic signed [CMP_W-1:0] dir_y_ext;
    logic signed [CMP_W-1:0] z_ext;
    logic signed [CMP_W-1:0] prod_x;
    logic signed [CMP_W-1:0] prod_y;
    logic signed [CMP_W-1:0] lo_x;
    logic signed [CMP_W-1:0] hi_x;
    logic signed [CMP_W-1:0] lo_y;
    logic signed [CMP_W-1:0] hi_y;
    logic                    is_hit;
    logic                    is_better;

    ////////////////////////////////////////
    // hit test on the returned entry
    ////////////////////////////////////////

    // compare dir * z against corner << FOCAL_SHIFT, no divide needed
    always_comb begin
        entry     = bus.rdata.entry;
        dir_x_ext = CMP_W'($signed(ray_q.dir_x));
        dir_y_ext = CMP_W'($signed(ray_q.dir_y));
        z_ext     = CMP_W'($signed({1'b0, entry.z}));
        prod_x    = dir_x_ext * z_ext;
        prod_y    = dir_y_ext * z_ext;
        lo_x      = CMP_W'($signed(entry.x)) <<< FOCAL_SHIFT;
        hi_x      = (CMP_W'($signed(entry.x)) + CMP_W'(BLOCK_SIZE)) <<< FOCAL_SHIFT;
        lo_y      = CMP_W'($signed(entry.y)) <<< FOCAL_SHIFT;
        hi_y      = (CMP_W'($signed(entry.y)) + CMP_W'(BLOCK_SIZE)) <<< FOCAL_SHIFT;
        is_hit    = entry.visible && (prod_x >= lo_x) && (prod_x < hi_x)
                    && (prod_y >= lo_y) && (prod_y < hi_y);
        // strict less keeps the lower index on a tie
        is_better = is_hit && ((hit_block == NO_HIT) || (entry.z < hit_depth));
    end

    // read only port into the table
    assign bus.req   = (state == ST_ISSUE);
    assign bus.we    = 1'b0;
    assign bus.addr  = idx;
    assign bus.wdata = '0;

    assign ray_ready = (state == ST_IDLE);
    assign hit_valid = (state == ST_DONE);
    assign hit_x     = ray_q.pix_x;
    assign hit_y     = ray_q.pix_y;

    ////////////////////////////////////////
    // scan control
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= ST_IDLE;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= bus.gnt;
            case (state)
                ST_IDLE:  if (ray_valid) state <= ST_ISSUE;
                ST_ISSUE: if (bus.gnt && idx == LAST_IDX) state <= ST_DRAIN;
                // last word comes back here
                ST_DRAIN: if (rd_pending) state <= ST_DONE;
                ST_DONE:  if (hit_ready) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // running best, frozen once the scan is done
    always_ff @(posedge clk_in) begin
        rd_idx <= idx;
        if (ray_valid && ray_ready) begin
            ray_q     <= ray;
            idx       <= '0;
            hit_block <= NO_HIT;
            hit_depth <= '0;
        end else begin
            if (bus.gnt) begin
                idx <= idx + 1'b1;
            end
            if (rd_pending && is_better) begin
                hit_block <= rd_idx;
                hit_depth <= entry.z;
            end
        end
    end

    a_hit_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        hit_valid && !hit_ready |=> hit_valid
        && $stable({hit_x, hit_y, hit_block, hit_depth}));

endmodule

// File: source/pixel_ray_gen.sv
`timescale 1ns/1ps

module pixel_ray_gen import raycast_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic [PIX_X_W-1:0] pixel_x,
    input  logic [PIX_Y_W-1:0] pixel_y,
    input  logic               pixel_valid,
    output logic               pixel_ready,
    output ray_dir_t           ray,
    output logic               ray_valid,
    input  logic               ray_ready
);

    localparam logic signed [DIR_X_W-1:0] CENTER_X = DIR_X_W'(SCREEN_W / 2);
    localparam logic signed [DIR_Y_W-1:0] CENTER_Y = DIR_Y_W'(SCREEN_H / 2);

    logic signed [DIR_X_W-1:0] dir_x;
    logic signed [DIR_Y_W-1:0] dir_y;
    logic                      take;

    // camera at the origin looking down +z, screen centre on the axis
    always_comb begin
        dir_x = $signed({1'b0, pixel_x}) - CENTER_X;
        dir_y = $signed({1'b0, pixel_y}) - CENTER_Y;
    end

    // accept when empty or draining this cycle
    assign pixel_ready = !ray_valid || ray_ready;
    assign take        = pixel_valid && pixel_ready;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ray_valid <= 1'b0;
        end else if (pixel_ready) begin
            ray_valid <= pixel_valid;
        end
    end

    ////////////////////////////////////////
    // payload stage
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (take) begin
            ray.dir_x <= dir_x;
            ray.dir_y <= dir_y;
            ray.pix_x <= pixel_x;
            ray.pix_y <= pixel_y;
        end
    end

endmodule

// File: source/ray_caster_top.sv
`timescale 1ns/1ps

module ray_caster_top import raycast_pkg::*; #(
    parameter int NUM_BLOCKS  = 12,
    parameter int FOCAL_SHIFT = 8,
    parameter int BLOCK_SIZE  = 64
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    // apb table access
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [BLK_IDX_W-1:0] paddr,
    input  logic [WORD_W-1:0]    pwdata,
    output logic [WORD_W-1:0]    prdata,
    output logic                 pready,
    output logic                 pslverr,
    // pixel in
    input  logic [PIX_X_W-1:0]   pixel_x,
    input  logic [PIX_Y_W-1:0]   pixel_y,
    input  logic                 pixel_valid,
    output logic                 pixel_ready,
    // nearest hit out
    output logic [PIX_X_W-1:0]   hit_x,
    output logic [PIX_Y_W-1:0]   hit_y,
    output logic [BLK_IDX_W-1:0] hit_block,
    output logic [DEPTH_W-1:0]   hit_depth,
    output logic                 hit_valid,
    input  logic                 hit_ready
);

    ray_dir_t ray;
    logic     ray_valid;
    logic     ray_ready;

    block_bus_if apb_bus ();
    block_bus_if scan_bus ();

    apb_block_port #(.NUM_BLOCKS(NUM_BLOCKS)) u_apb (
        .clk_in, .rst_in, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .bus(apb_bus)
    );

    block_table_arbiter #(.NUM_BLOCKS(NUM_BLOCKS)) u_arb (
        .clk_in, .rst_in, .apb_bus(apb_bus), .scan_bus(scan_bus)
    );

    pixel_ray_gen u_ray_gen (
        .clk_in, .rst_in, .pixel_x, .pixel_y, .pixel_valid, .pixel_ready,
        .ray, .ray_valid, .ray_ready
    );

    get_intersecting_block #(
        .NUM_BLOCKS(NUM_BLOCKS), .FOCAL_SHIFT(FOCAL_SHIFT), .BLOCK_SIZE(BLOCK_SIZE)
    ) u_scan (
        .clk_in, .rst_in, .ray, .ray_valid, .ray_ready, .bus(scan_bus),
        .hit_x, .hit_y, .hit_block, .hit_depth, .hit_valid, .hit_ready
    );

endmodule

// File: source/raycast_pkg.sv
package raycast_pkg;

    ////////////////////////////////////////
    // screen and pixel geometry
    ////////////////////////////////////////

    localparam int PIX_X_W  = 11;
    localparam int PIX_Y_W  = 10;
    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;

    // one extra bit so the centred direction stays signed
    localparam int DIR_X_W = PIX_X_W + 1;
    localparam int DIR_Y_W = PIX_Y_W + 1;

    ////////////////////////////////////////
    // block table
    ////////////////////////////////////////

    localparam int WORD_W    = 32;
    localparam int BLK_IDX_W = 4;
    localparam int DEPTH_W   = 9;
    localparam int COORD_W   = 11;

    // index reported when no block is hit
    localparam logic [BLK_IDX_W-1:0] NO_HIT = BLK_IDX_W'(15);

    // front face of one block, lower corner at (x, y)
    typedef struct packed {
        logic                      visible;
        logic [DEPTH_W-1:0]        z;
        logic signed [COORD_W-1:0] y;
        logic signed [COORD_W-1:0] x;
    } block_entry_t;

    // apb side sees the raw word, scanner sees the entry
    typedef union packed {
        logic [WORD_W-1:0] raw;
        block_entry_t      entry;
    } block_word_u;

    // centred ray direction plus the pixel it came from
    typedef struct packed {
        logic signed [DIR_X_W-1:0] dir_x;
        logic signed [DIR_Y_W-1:0] dir_y;
        logic [PIX_X_W-1:0]        pix_x;
        logic [PIX_Y_W-1:0]        pix_y;
    } ray_dir_t;

endpackage

// File: verif/ray_caster_patterns.txt
# W addr word | R addr word slverr | P pixel_x pixel_y block depth | S stall
# W and R fields are hex, P and S fields are decimal
P 512 384 15 0
P 0 0 15 0
W 0 C0000000
W 1 12345678
R 0 C0000000 0
R 1 12345678 0
R C 00000000 1
P 512 384 0 256
P 575 447 0 256
P 576 400 15 0
P 511 400 15 0
P 540 448 15 0
P 540 383 15 0
W 3 C0000020
P 552 400 0 256
P 600 400 3 256
W 2 A0000000
P 552 400 2 128
P 600 400 2 128
W 4 C03E07C0
W 5 103E07C0
P 448 320 4 256
P 447 320 15 0
P 480 350 4 256
S 1
P 520 390 2 128
R 0 C0000000 0
P 470 340 4 256
R 3 C0000020 0
P 560 420 2 128
R 5 103E07C0 0
P 1000 700 15 0
R D 00000000 1
P 448 383 4 256
R 4 C03E07C0 0
S 0
P 640 511 15 0
P 639 511 2 128

// File: verif/ray_caster_tb.sv
`timescale 1ns/1ps

module ray_caster_tb import raycast_pkg::*; ();

    localparam int    NUM_BLOCKS   = 12;
    localparam string PATTERN_FILE = "verif/ray_caster_patterns.txt";

    logic                 clk_in;
    logic                 rst_in;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [BLK_IDX_W-1:0] paddr;
    logic [WORD_W-1:0]    pwdata;
    logic [WORD_W-1:0]    prdata;
    logic                 pready;
    logic                 pslverr;
    logic [PIX_X_W-1:0]   pixel_x;
    logic [PIX_Y_W-1:0]   pixel_y;
    logic                 pixel_valid;
    logic                 pixel_ready;
    logic [PIX_X_W-1:0]   hit_x;
    logic [PIX_Y_W-1:0]   hit_y;
    logic [BLK_IDX_W-1:0] hit_block;
    logic [DEPTH_W-1:0]   hit_depth;
    logic                 hit_valid;
    logic                 hit_ready;

    // parsed pattern commands
    string       cmd_q[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    logic [31:0] arg_c[$];
    logic [31:0] arg_d[$];
    int          num_cmds = 0;

    // expected results in pixel order
    logic [PIX_X_W-1:0]   exp_x[$];
    logic [PIX_Y_W-1:0]   exp_y[$];
    logic [BLK_IDX_W-1:0] exp_blk[$];
    logic [DEPTH_W-1:0]   exp_depth[$];
    int                   results_seen = 0;

    logic stall_on;
    int   word_errors   = 0;
    int   resp_errors   = 0;
    int   setup_errors  = 0;
    int   hit_errors    = 0;
    int   extra_results = 0;

    ray_caster_top DUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // random back-pressure on the hit port
    initial begin
        void'($urandom(32'hc257_ccbb));
        hit_ready = 1'b0;
        forever begin
            @(posedge clk_in);
            #10;
            hit_ready = stall_on ? 1'($urandom % 2) : 1'b1;
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_word(input block_word_u got, input block_word_u exp,
                              input logic [BLK_IDX_W-1:0] addr);
        if (got.raw !== exp.raw) begin
            word_errors++;
            $display("[FAIL] %0t ns: read of block %0d gave %h, expected %h",
                     $time, addr, got.raw, exp.raw);
        end
    endtask

    task automatic check_err(input logic got, input logic exp,
                             input logic [BLK_IDX_W-1:0] addr);
        if (got !== exp) begin
            resp_errors++;
            $display("[FAIL] %0t ns: access to block %0d gave pslverr %b, expected %b",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_hit(input logic [PIX_X_W-1:0] got_x, input logic [PIX_Y_W-1:0] got_y,
                             input logic [BLK_IDX_W-1:0] got_blk,
                             input logic [DEPTH_W-1:0] got_depth,
                             input logic [PIX_X_W-1:0] ex_x, input logic [PIX_Y_W-1:0] ex_y,
                             input logic [BLK_IDX_W-1:0] ex_blk,
                             input logic [DEPTH_W-1:0] ex_depth);
        if (got_x !== ex_x || got_y !== ex_y || got_blk !== ex_blk || got_depth !== ex_depth)
        begin
            hit_errors++;
            $display("[FAIL] %0t ns: pixel (%0d,%0d) block %0d depth %0d, expected (%0d,%0d) %0d %0d",
                     $time, got_x, got_y, got_blk, got_depth, ex_x, ex_y, ex_blk, ex_depth);
        end
    endtask

    // one expected entry per hit transfer
    always @(negedge clk_in) begin
        if (!rst_in && hit_valid && hit_ready) begin
            if (results_seen >= exp_blk.size()) begin
                extra_results++;
                $display("%0t ns: a result came out with no pixel waiting for it", $time);
            end else begin
                check_hit(hit_x, hit_y, hit_block, hit_depth, exp_x[results_seen],
                          exp_y[results_seen], exp_blk[results_seen], exp_depth[results_seen]);
            end
            results_seen++;
        end
    end

    initial begin
        wait (num_cmds > 0);
        repeat (num_cmds * (NUM_BLOCKS + 20) * 4) @(posedge clk_in);
        $display("watchdog expired, the DUT stopped answering before the patterns ended");
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // bus and pixel drivers
    ////////////////////////////////////////

    task automatic apb_access(input logic write, input logic [BLK_IDX_W-1:0] addr,
                              input logic [WORD_W-1:0] wdata,
                              output logic [WORD_W-1:0] rdata, output logic err);
        @(posedge clk_in);
        #10;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk_in);
        #10;
        penable = 1'b1;
        do @(negedge clk_in); while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_in);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_pixel(input logic [PIX_X_W-1:0] x, input logic [PIX_Y_W-1:0] y,
                              input logic [BLK_IDX_W-1:0] blk, input logic [DEPTH_W-1:0] depth);
        @(posedge clk_in);
        #10;
        pixel_x     = x;
        pixel_y     = y;
        pixel_valid = 1'b1;
        do @(negedge clk_in); while (!pixel_ready);
        @(posedge clk_in);
        #10;
        pixel_valid = 1'b0;
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_blk.push_back(blk);
        exp_depth.push_back(depth);
    endtask

    task automatic wait_for_results();
        while (results_seen < exp_blk.size()) @(posedge clk_in);
    endtask

    task automatic load_patterns(input int fd);
        string       tok;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        while ($fscanf(fd, "%s", tok) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            if (tok.getc(0) == "#") begin
                void'($fgets(line, fd));
            end else begin
                case (tok)
                    "W": void'($fscanf(fd, "%h %h", a, b));
                    "R": void'($fscanf(fd, "%h %h %h", a, b, c));
                    "P": void'($fscanf(fd, "%d %d %d %d", a, b, c, d));
                    "S": void'($fscanf(fd, "%d", a));
                    default: begin
                        setup_errors++;
                        $display("unknown command %s in the pattern file", tok);
                    end
                endcase
                cmd_q.push_back(tok);
                arg_a.push_back(a);
                arg_b.push_back(b);
                arg_c.push_back(c);
                arg_d.push_back(d);
            end
        end
    endtask

    task automatic run_command(input int i);
        logic [WORD_W-1:0] rdata;
        logic              err;
        case (cmd_q[i])
            "W": begin
                // table changes only between pixels
                wait_for_results();
                apb_access(1'b1, arg_a[i][BLK_IDX_W-1:0], arg_b[i], rdata, err);
                check_err(err, 1'b0, arg_a[i][BLK_IDX_W-1:0]);
            end
            "R": begin
                apb_access(1'b0, arg_a[i][BLK_IDX_W-1:0], '0, rdata, err);
                check_err(err, arg_c[i][0], arg_a[i][BLK_IDX_W-1:0]);
                if (arg_c[i][0] == 1'b0) begin
                    check_word(block_word_u'(rdata), block_word_u'(arg_b[i]),
                               arg_a[i][BLK_IDX_W-1:0]);
                end
            end
            "P": send_pixel(arg_a[i][PIX_X_W-1:0], arg_b[i][PIX_Y_W-1:0],
                            arg_c[i][BLK_IDX_W-1:0], arg_d[i][DEPTH_W-1:0]);
            "S": stall_on = arg_a[i][0];
            default: stall_on = stall_on;
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int fd;
        int total;
        rst_in      = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pixel_x     = '0;
        pixel_y     = '0;
        pixel_valid = 1'b0;
        stall_on    = 1'b0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            setup_errors++;
            $display("could not open the pattern file %s", PATTERN_FILE);
        end else begin
            load_patterns(fd);
            $fclose(fd);
        end
        num_cmds = cmd_q.size();
        repeat (3) @(posedge clk_in);
        #10;
        rst_in = 1'b0;
        foreach (cmd_q[i]) begin
            run_command(i);
        end
        wait_for_results();
        repeat (4) @(posedge clk_in);
        total = word_errors + resp_errors + hit_errors + extra_results + setup_errors;
        $display("errors: read data %0d, slave response %0d, hit %0d, extra results %0d, setup %0d",
                 word_errors, resp_errors, hit_errors, extra_results, setup_errors);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
